//--- bench/fetch_properties.sv
//--------------------------------------------------
// handshake and credit assertions on the fetch stage
// attached to every fetch_top instance by bind
//--------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_properties
  import mem_pkg::*;
  import fetch_pkg::*;
(
  input logic                  clk,
  input logic                  rst_n,
  input logic                  d_val,
  input logic                  d_rdy,
  input f_d_msg_t              d_msg,
  input mem_req_t              mem_req,
  input logic                  mem_req_val,
  input logic                  mem_req_rdy,
  input logic [`QCNT_BITS-1:0] queue_count,
  input redirect_t             redirect
);

  // count of failed assertions
  int unsigned fails = 0;

  // decode message held while stalled
  d_msg_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (d_val && !d_rdy) |=> $stable(d_msg))
    else begin
      $error("d_msg changed while d_val high and d_rdy low");
      fails++;
    end

  // memory request held until taken
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req_val && !mem_req_rdy) |=> $stable(mem_req))
    else begin
      $error("mem_req changed while waiting for mem_req_rdy");
      fails++;
    end

  // credit keeps the queue from overflowing
  queue_bound: assert property (@(posedge clk) disable iff (!rst_n)
    queue_count <= `QUEUE_DEPTH)
    else begin
      $error("queue occupancy above depth");
      fails++;
    end

  // flush masks the head in the redirect cycle
  redirect_mask: assert property (@(posedge clk) disable iff (!rst_n)
    redirect.val |-> !d_val)
    else begin
      $error("d_val high in a redirect cycle");
      fails++;
    end

endmodule

bind fetch_top fetch_properties fetch_properties_inst (
  .clk, .rst_n, .d_val, .d_rdy, .d_msg,
  .mem_req, .mem_req_val, .mem_req_rdy,
  .queue_count, .redirect
);

`default_nettype wire

//--- bench/fetch_tb.sv
//--------------------------------------------------
// fetch stage testbench
// loads a random image, runs six stream tests
// and checks every transfer against the image
//--------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb
  import fetch_pkg::*;
();

  localparam int WORD_BITS   = $clog2(`MEM_WORDS);
  // transfers asked for over all six tests
  localparam int TOTAL_XFERS = 32 + 32 + 24 + 32 + 16 + 20;
  localparam int NUM_TESTS   = 6;
  // reset and load per test plus up to 8 cycles per transfer
  localparam int CYCLE_LIMIT = NUM_TESTS * (`MEM_WORDS + 8) + TOTAL_XFERS * 8 + 300;

  logic                  clk;
  logic                  rst_n;
  logic                  fetch_en;
  redirect_t             redirect;
  logic                  d_val;
  f_d_msg_t              d_msg;
  logic                  d_rdy;
  logic                  load_en;
  logic [`ADDR_BITS-1:0] load_addr;
  logic [`INST_BITS-1:0] load_data;

  logic [`INST_BITS-1:0] image [`MEM_WORDS];
  logic [`ADDR_BITS-1:0] exp_pc;
  logic                  rdy_random;
  logic [31:0]           rnd;
  integer                seed = 32'h920c;
  int                    xfers = 0;
  int                    errors = 0;
  int                    test_err0 = 0;
  int                    cycles = 0;
  int                    total_err;

  fetch_top fetch_top_inst (
    .clk, .rst_n, .fetch_en, .redirect,
    .d_val, .d_msg, .d_rdy,
    .load_en, .load_addr, .load_data
  );

  always #2 clk = ~clk;

  //------------------------------------------------
  // reference model and compare
  //------------------------------------------------

  // image word the memory should return for a pc
  function automatic logic [`INST_BITS-1:0] ref_inst(input logic [`ADDR_BITS-1:0] pc);
    return image[pc[WORD_BITS+1:2]];
  endfunction

  // expected pc follows reset, redirect and accepted transfers
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_pc = `RST_ADDR;
    end else if (redirect.val) begin
      exp_pc = redirect.target;
    end else if (d_val && d_rdy) begin
      xfers++;
      if (d_msg.pc !== exp_pc) begin
        $display("FAILED d_msg.pc 0x%h expected 0x%h", d_msg.pc, exp_pc);
        errors++;
      end
      if (d_msg.inst !== ref_inst(exp_pc)) begin
        $display("FAILED d_msg.inst 0x%h expected 0x%h", d_msg.inst, ref_inst(exp_pc));
        errors++;
      end
      exp_pc = exp_pc + `ADDR_BITS'(4);
    end
  end

  // decode stall pattern picked at the edge and driven 1 ns later
  always @(posedge clk) begin
    if (rdy_random) begin
      rnd = $random(seed);
      #1;
      d_rdy = rnd[0];
    end else begin
      #1;
      d_rdy = 1'b1;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the stream stalled", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  //------------------------------------------------
  // stimulus helpers
  //------------------------------------------------

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // fresh random image through the load port
  task automatic load_image();
    for (int i = 0; i < `MEM_WORDS; i++) begin
      image[i]  = $random(seed);
      load_en   = 1'b1;
      load_addr = `ADDR_BITS'(i * 4);
      load_data = image[i];
      step();
    end
    load_en = 1'b0;
  endtask

  // idle inputs then 2 cycle reset and reload
  task automatic start_test();
    fetch_en   = 1'b0;
    rdy_random = 1'b0;
    rst_n      = 1'b0;
    step();
    step();
    rst_n = 1'b1;
    load_image();
    test_err0 = errors;
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s finished with %0d errors", num, name, errors - test_err0);
  endtask

  task automatic wait_xfers(input int n);
    int goal;
    goal = xfers + n;
    while (xfers < goal) step();
  endtask

  // one cycle redirect pulse
  task automatic send_redirect(input logic [`ADDR_BITS-1:0] target);
    redirect.val    = 1'b1;
    redirect.target = target;
    step();
    redirect = '0;
  endtask

  // wait until the queue stays empty for a few cycles
  task automatic drain_queue();
    int quiet;
    quiet = 0;
    while (quiet < 4) begin
      step();
      if (d_val) quiet = 0;
      else quiet++;
    end
  endtask

  task automatic idle_check(input int n);
    repeat (n) begin
      step();
      if (d_val) begin
        $display("FAILED d_val 0x%h expected 0x%h", d_val, 1'b0);
        errors++;
      end
    end
  endtask

  //------------------------------------------------
  // tests
  //------------------------------------------------

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    fetch_en   = 1'b0;
    redirect   = '0;
    d_rdy      = 1'b1;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    rdy_random = 1'b0;

    start_test();
    fetch_en = 1'b1;
    wait_xfers(32);
    end_test(1, "sequential stream");

    start_test();
    rdy_random = 1'b1;
    fetch_en   = 1'b1;
    wait_xfers(32);
    end_test(2, "back-pressure");

    start_test();
    fetch_en = 1'b1;
    wait_xfers(10);
    send_redirect(`RST_ADDR + 16'h0080);
    wait_xfers(14);
    end_test(3, "forward redirect");

    // same lower target each time so old path pcs would mismatch
    start_test();
    rdy_random = 1'b1;
    fetch_en   = 1'b1;
    for (int i = 0; i < 4; i++) begin
      wait_xfers(6);
      send_redirect(16'h00c0);
    end
    wait_xfers(8);
    end_test(4, "backward redirect under back-pressure");

    start_test();
    idle_check(12);
    fetch_en = 1'b1;
    wait_xfers(8);
    fetch_en = 1'b0;
    drain_queue();
    idle_check(12);
    fetch_en = 1'b1;
    wait_xfers(8);
    end_test(5, "fetch enable");

    // reset with fetch_en held high
    start_test();
    fetch_en = 1'b1;
    wait_xfers(10);
    rst_n = 1'b0;
    step();
    step();
    rst_n = 1'b1;
    wait_xfers(10);
    end_test(6, "reset restart");

    total_err = errors + int'(fetch_top_inst.fetch_properties_inst.fails);
    $display("transfers %0d, errors %0d", xfers, total_err);
    if (total_err == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- include/fetch_macros.svh
//--------------------------------------------------
// widths and sizes shared by the fetch stage
// include before any package or module using them
//--------------------------------------------------
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// byte address and instruction word widths
`define ADDR_BITS 16
`define INST_BITS 32

// request tag, carries the fetch epoch
`define OPAQ_BITS 4

// first pc after reset
`define RST_ADDR 16'h0100

// memory depth in words, queue depth in entries (power of two)
`define MEM_WORDS 256
`define QUEUE_DEPTH 4
`define QCNT_BITS ($clog2(`QUEUE_DEPTH) + 1)

`endif

//--- logic/fetch_pkg.sv
//--------------------------------------------------
// fetch side types: message to decode, redirect
// from decode and the issue state of the fetch unit
//--------------------------------------------------
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  // instruction handed to decode with its pc
  typedef struct packed {
    logic [`INST_BITS-1:0] inst;
    logic [`ADDR_BITS-1:0] pc;
  } f_d_msg_t;

  // branch or jump target, val is a one cycle pulse
  typedef struct packed {
    logic                  val;
    logic [`ADDR_BITS-1:0] target;
  } redirect_t;

  // issue state
  typedef enum logic {
    FETCH_IDLE,
    FETCH_RUN
  } fetch_state_e;

endpackage

`default_nettype wire

//--- logic/fetch_queue.sv
//--------------------------------------------------
// circular FIFO of fetched instructions in front of
// decode; flush empties it on a redirect
//--------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_queue
  import fetch_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enq_val,
  input  f_d_msg_t              enq_msg,
  input  logic                  flush,
  output logic                  d_val,
  output f_d_msg_t              d_msg,
  input  logic                  d_rdy,
  output logic [`QCNT_BITS-1:0] count
);

  // depth is a power of two, pointers wrap by themselves
  localparam int PTR_BITS = $clog2(`QUEUE_DEPTH);

  f_d_msg_t            entries [`QUEUE_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic                push;
  logic                pop;

  // head entry, hidden during a flush
  assign d_val = (count != '0) && !flush;
  assign d_msg = entries[rd_ptr];
  assign pop   = d_val && d_rdy;
  // never full on a push, fetch unit holds credit
  assign push  = enq_val && !flush;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      // push and pop together leave count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= enq_msg;
    end
  end

endmodule

`default_nettype wire

//--- logic/fetch_top.sv
//--------------------------------------------------
// fetch stage top: fetch unit, instruction memory
// and the queue that feeds decode
//--------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_top
  import mem_pkg::*;
  import fetch_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_en,
  input  redirect_t             redirect,
  output logic                  d_val,
  output f_d_msg_t              d_msg,
  input  logic                  d_rdy,
  input  logic                  load_en,
  input  logic [`ADDR_BITS-1:0] load_addr,
  input  logic [`INST_BITS-1:0] load_data
);

  // memory channel
  mem_req_t  mem_req;
  logic      mem_req_val;
  logic      mem_req_rdy;
  mem_resp_t mem_resp;
  logic      mem_resp_val;
  logic      mem_resp_rdy;

  // queue channel
  logic                  enq_val;
  f_d_msg_t              enq_msg;
  logic                  flush;
  logic [`QCNT_BITS-1:0] queue_count;

  fetch_unit fetch_unit_inst (
    .clk, .rst_n, .fetch_en, .redirect,
    .mem_req, .mem_req_val, .mem_req_rdy,
    .mem_resp, .mem_resp_val, .mem_resp_rdy,
    .enq_val, .enq_msg, .flush, .queue_count
  );

  inst_mem inst_mem_inst (
    .clk, .rst_n,
    .mem_req, .mem_req_val, .mem_req_rdy,
    .mem_resp, .mem_resp_val, .mem_resp_rdy,
    .load_en, .load_addr, .load_data
  );

  fetch_queue fetch_queue_inst (
    .clk, .rst_n, .enq_val, .enq_msg, .flush,
    .d_val, .d_msg, .d_rdy,
    .count (queue_count)
  );

endmodule

`default_nettype wire

//--- logic/fetch_unit.sv
//--------------------------------------------------
// pc generation and request issue under credit,
// epoch tagging, drop of stale responses
//--------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_unit
  import mem_pkg::*;
  import fetch_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_en,
  input  redirect_t             redirect,
  // memory request
  output mem_req_t              mem_req,
  output logic                  mem_req_val,
  input  logic                  mem_req_rdy,
  // memory response
  input  mem_resp_t             mem_resp,
  input  logic                  mem_resp_val,
  output logic                  mem_resp_rdy,
  // queue side
  output logic                  enq_val,
  output f_d_msg_t              enq_msg,
  output logic                  flush,
  input  logic [`QCNT_BITS-1:0] queue_count
);

  fetch_state_e          state;
  logic [`ADDR_BITS-1:0] pc;
  logic [`OPAQ_BITS-1:0] epoch;
  // requests of the current epoch not yet back
  logic [`QCNT_BITS-1:0] inflight;
  logic [`QCNT_BITS:0]   used;
  logic                  has_credit;
  logic                  issue;

  //------------------------------------------------
  // credit and issue
  //------------------------------------------------

  // slots already claimed, in flight or queued
  assign used       = {1'b0, inflight} + {1'b0, queue_count};
  assign has_credit = used < `QUEUE_DEPTH;

  // nothing issued in a redirect cycle, next one is the target
  assign mem_req_val    = (state == FETCH_RUN) && has_credit && !redirect.val;
  assign mem_req.addr   = pc;
  assign mem_req.opaque = epoch;
  assign issue          = mem_req_val && mem_req_rdy;

  //------------------------------------------------
  // response path
  //------------------------------------------------

  // every response is taken, stale ones just vanish
  assign mem_resp_rdy = 1'b1;

  // tag must match the live epoch
  assign enq_val      = mem_resp_val && (mem_resp.opaque == epoch) && !redirect.val;
  assign enq_msg.inst = mem_resp.data;
  assign enq_msg.pc   = mem_resp.addr;
  assign flush        = redirect.val;

  //------------------------------------------------
  // state
  //------------------------------------------------

  // issue follows the fetch_en level
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= FETCH_IDLE;
    end else begin
      case (state)
        FETCH_IDLE: if (fetch_en)  state <= FETCH_RUN;
        FETCH_RUN:  if (!fetch_en) state <= FETCH_IDLE;
        default:    state <= FETCH_IDLE;
      endcase
    end
  end

  // redirect wins over sequential step
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RST_ADDR;
    end else if (redirect.val) begin
      pc <= redirect.target;
    end else if (issue) begin
      pc <= pc + `ADDR_BITS'(4);
    end
  end

  // new epoch per redirect, old tags then mismatch
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      epoch <= '0;
    end else if (redirect.val) begin
      epoch <= epoch + 1'b1;
    end
  end

  // old path requests no longer hold credit after a redirect
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inflight <= '0;
    end else if (redirect.val) begin
      inflight <= '0;
    end else begin
      case ({issue, enq_val})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/inst_mem.sv
//--------------------------------------------------
// word addressed instruction memory, written through
// a load port, read with a one entry response stage
//--------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "fetch_macros.svh"

module inst_mem
  import mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // read request channel
  input  mem_req_t              mem_req,
  input  logic                  mem_req_val,
  output logic                  mem_req_rdy,
  // read response channel
  output mem_resp_t             mem_resp,
  output logic                  mem_resp_val,
  input  logic                  mem_resp_rdy,
  // load port
  input  logic                  load_en,
  input  logic [`ADDR_BITS-1:0] load_addr,
  input  logic [`INST_BITS-1:0] load_data
);

  // word index bits above the byte offset
  localparam int WORD_BITS = $clog2(`MEM_WORDS);

  logic [`INST_BITS-1:0] mem [`MEM_WORDS];

  logic      resp_full;
  mem_resp_t resp_q;
  logic      req_go;

  //------------------------------------------------
  // handshake
  //------------------------------------------------

  // accept when stage is empty or drains this cycle
  assign mem_req_rdy  = !resp_full || mem_resp_rdy;
  assign req_go       = mem_req_val && mem_req_rdy;
  assign mem_resp_val = resp_full;
  assign mem_resp     = resp_q;

  //------------------------------------------------
  // storage
  //------------------------------------------------

  // load port write, byte offset dropped
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr[WORD_BITS+1:2]] <= load_data;
    end
  end

  //------------------------------------------------
  // response stage
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      resp_full <= 1'b0;
    end else if (req_go) begin
      resp_full <= 1'b1;
    end else if (mem_resp_rdy) begin
      resp_full <= 1'b0;
    end
  end

  // data, address and tag held until consumed
  always_ff @(posedge clk) begin
    if (req_go) begin
      resp_q.data   <= mem[mem_req.addr[WORD_BITS+1:2]];
      resp_q.addr   <= mem_req.addr;
      resp_q.opaque <= mem_req.opaque;
    end
  end

endmodule

`default_nettype wire

//--- logic/mem_pkg.sv
//--------------------------------------------------
// request and response types of the instruction
// memory channel, shared by memory and fetch unit
//--------------------------------------------------
`default_nettype none

`include "fetch_macros.svh"

package mem_pkg;

  // read request, tag is opaque to the memory
  typedef struct packed {
    logic [`ADDR_BITS-1:0] addr;
    logic [`OPAQ_BITS-1:0] opaque;
  } mem_req_t;

  // read response, address and tag echoed back
  typedef struct packed {
    logic [`INST_BITS-1:0] data;
    logic [`ADDR_BITS-1:0] addr;
    logic [`OPAQ_BITS-1:0] opaque;
  } mem_resp_t;

endpackage

`default_nettype wire

//--- verilog.f
+incdir+include
logic/mem_pkg.sv
logic/fetch_pkg.sv
logic/inst_mem.sv
logic/fetch_queue.sv
logic/fetch_unit.sv
logic/fetch_top.sv
bench/fetch_properties.sv
bench/fetch_tb.sv
